// ==== design/gpio_pkg.sv ====
package gpio_pkg;

    //////////////////////////////////////////////////
    // Address map and sizes
    //////////////////////////////////////////////////

    localparam int ALEN = 16;
    localparam int DLEN = 64;

    localparam int NUM_OUT = 16;
    localparam int NUM_IN = 12;

    // Each bank is at least one data word wide, so a full read at offset 0 always fits.
    localparam int OUT_REG_SIZE = (NUM_OUT < 8) ? 8 : NUM_OUT;
    localparam int IN_REG_SIZE = (NUM_IN < 8) ? 8 : NUM_IN;

    // Address bits 15..12 pick the bank, the low 12 bits are the offset inside it.
    localparam int BANK_SEL_LSB = 12;
    localparam logic [ALEN-1:0] OFFSET_MASK = 16'h0FFF;

    //////////////////////////////////////////////////
    // Enums
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    // Where the decoder sends the transaction currently held on a channel.
    typedef enum logic [1:0] {
        IDLE,
        TO_OUT,
        TO_IN,
        TO_ERR
    } route_e;

    //////////////////////////////////////////////////
    // AXI4-Lite channel payloads
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [ALEN-1:0] awaddr;
    } axil_aw_t;

    typedef struct packed {
        logic [DLEN-1:0]   wdata;
        logic [DLEN/8-1:0] wstrb;
    } axil_w_t;

    typedef struct packed {
        resp_e bresp;
    } axil_b_t;

    typedef struct packed {
        logic [ALEN-1:0] araddr;
    } axil_ar_t;

    typedef struct packed {
        logic [DLEN-1:0] rdata;
        resp_e           rresp;
    } axil_r_t;

endpackage

// ==== design/axil_decoder.sv ====
`timescale 1ns/10ps

module axil_decoder (
    input  logic                bus,
    input  logic                rst,

    input  gpio_pkg::axil_aw_t  aw,
    input  logic                awvalid,
    output logic                awready,
    input  gpio_pkg::axil_w_t   w,
    input  logic                wvalid,
    output logic                wready,
    output gpio_pkg::axil_b_t   b,
    output logic                bvalid,
    input  logic                bready,
    input  gpio_pkg::axil_ar_t  ar,
    input  logic                arvalid,
    output logic                arready,
    output gpio_pkg::axil_r_t   r,
    output logic                rvalid,
    input  logic                rready,

    output gpio_pkg::axil_aw_t  out_aw,
    output logic                out_awvalid,
    input  logic                out_awready,
    output gpio_pkg::axil_w_t   out_w,
    output logic                out_wvalid,
    input  logic                out_wready,
    input  gpio_pkg::axil_b_t   out_b,
    input  logic                out_bvalid,
    output logic                out_bready,
    output gpio_pkg::axil_ar_t  out_ar,
    output logic                out_arvalid,
    input  logic                out_arready,
    input  gpio_pkg::axil_r_t   out_r,
    input  logic                out_rvalid,
    output logic                out_rready,

    output gpio_pkg::axil_ar_t  in_ar,
    output logic                in_arvalid,
    input  logic                in_arready,
    input  gpio_pkg::axil_r_t   in_r,
    input  logic                in_rvalid,
    output logic                in_rready
);
    gpio_pkg::route_e wr_route;
    gpio_pkg::route_e rd_route;
    logic err_bvalid;
    logic err_rvalid;

    //////////////////////////////////////////////////
    // Write channel
    //////////////////////////////////////////////////

    // The input bank has no writable state, so only bank 0 is a legal write target.
    always_ff @(posedge bus) begin
        if (rst) begin
            wr_route <= gpio_pkg::IDLE;
            err_bvalid <= 1'b0;
        end else begin
            case (wr_route)
                gpio_pkg::IDLE: begin
                    if (awvalid && wvalid) begin
                        if (aw.awaddr[gpio_pkg::ALEN-1:gpio_pkg::BANK_SEL_LSB] == '0) begin
                            wr_route <= gpio_pkg::TO_OUT;
                        end else begin
                            wr_route <= gpio_pkg::TO_ERR;
                        end
                    end
                end
                default: begin
                    if (bvalid && bready) begin
                        wr_route <= gpio_pkg::IDLE;
                    end
                end
            endcase

            if (bvalid && bready) begin
                err_bvalid <= 1'b0;
            end else if (wr_route == gpio_pkg::TO_ERR && awvalid && awready) begin
                err_bvalid <= 1'b1;
            end
        end
    end

    always_comb begin
        out_aw = '0;
        out_awvalid = 1'b0;
        out_w = '0;
        out_wvalid = 1'b0;
        out_bready = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        b = '0;
        bvalid = 1'b0;
        case (wr_route)
            gpio_pkg::TO_OUT: begin
                out_aw = aw;
                out_awvalid = awvalid;
                out_w = w;
                out_wvalid = wvalid;
                out_bready = bready;
                awready = out_awready;
                wready = out_wready;
                b = out_b;
                bvalid = out_bvalid;
            end
            gpio_pkg::TO_ERR: begin
                awready = awvalid && wvalid && !err_bvalid;
                wready = awvalid && wvalid && !err_bvalid;
                b.bresp = gpio_pkg::DECERR;
                bvalid = err_bvalid;
            end
            default: begin
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Read channel
    //////////////////////////////////////////////////

    always_ff @(posedge bus) begin
        if (rst) begin
            rd_route <= gpio_pkg::IDLE;
            err_rvalid <= 1'b0;
        end else begin
            case (rd_route)
                gpio_pkg::IDLE: begin
                    if (arvalid) begin
                        case (ar.araddr[gpio_pkg::ALEN-1:gpio_pkg::BANK_SEL_LSB])
                            4'd0: rd_route <= gpio_pkg::TO_OUT;
                            4'd1: rd_route <= gpio_pkg::TO_IN;
                            default: rd_route <= gpio_pkg::TO_ERR;
                        endcase
                    end
                end
                default: begin
                    if (rvalid && rready) begin
                        rd_route <= gpio_pkg::IDLE;
                    end
                end
            endcase

            if (rvalid && rready) begin
                err_rvalid <= 1'b0;
            end else if (rd_route == gpio_pkg::TO_ERR && arvalid && arready) begin
                err_rvalid <= 1'b1;
            end
        end
    end

    always_comb begin
        out_ar = '0;
        out_arvalid = 1'b0;
        out_rready = 1'b0;
        in_ar = '0;
        in_arvalid = 1'b0;
        in_rready = 1'b0;
        arready = 1'b0;
        r = '0;
        rvalid = 1'b0;
        case (rd_route)
            gpio_pkg::TO_OUT: begin
                out_ar = ar;
                out_arvalid = arvalid;
                out_rready = rready;
                arready = out_arready;
                r = out_r;
                rvalid = out_rvalid;
            end
            gpio_pkg::TO_IN: begin
                in_ar = ar;
                in_arvalid = arvalid;
                in_rready = rready;
                arready = in_arready;
                r = in_r;
                rvalid = in_rvalid;
            end
            gpio_pkg::TO_ERR: begin
                arready = arvalid && !err_rvalid;
                r.rresp = gpio_pkg::DECERR;
                rvalid = err_rvalid;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== design/gpio_out_bank.sv ====
`timescale 1ns/10ps

module gpio_out_bank (
    input  logic                          bus,
    input  logic                          rst,
    input  gpio_pkg::axil_aw_t            aw,
    input  logic                          awvalid,
    output logic                          awready,
    input  gpio_pkg::axil_w_t             w,
    input  logic                          wvalid,
    output logic                          wready,
    output gpio_pkg::axil_b_t             b,
    output logic                          bvalid,
    input  logic                          bready,
    input  gpio_pkg::axil_ar_t            ar,
    input  logic                          arvalid,
    output logic                          arready,
    output gpio_pkg::axil_r_t             r,
    output logic                          rvalid,
    input  logic                          rready,
    output logic [gpio_pkg::NUM_OUT-1:0]  pins
);
    logic [gpio_pkg::OUT_REG_SIZE-1:0] pins_reg;

    logic [gpio_pkg::ALEN-1:0] waddr;
    logic [7:0] wstrb;
    logic [7:0] wbits;
    logic w_accept;
    logic w_fire;
    logic w_range_ok;

    logic [gpio_pkg::ALEN-1:0] raddr;
    logic [gpio_pkg::DLEN-1:0] rdata_comb;
    logic ar_accept;
    logic r_fire;
    logic r_range_ok;

    assign pins = pins_reg[gpio_pkg::NUM_OUT-1:0];

    //////////////////////////////////////////////////
    // Writes
    //////////////////////////////////////////////////

    // No new write is taken while a response is still waiting for bready.
    assign w_accept = awvalid && wvalid && !awready && !bvalid;
    assign w_fire = awvalid && awready && wvalid && wready;
    assign w_range_ok = (32'(waddr) + 8) <= gpio_pkg::OUT_REG_SIZE;

    always_ff @(posedge bus) begin
        if (w_accept) begin
            waddr <= aw.awaddr & gpio_pkg::OFFSET_MASK;
            wstrb <= w.wstrb;
            for (int i = 0; i < 8; i++) begin
                wbits[i] <= w.wdata[8*i];
            end
        end
        if (w_fire) begin
            b.bresp <= w_range_ok ? gpio_pkg::OKAY : gpio_pkg::SLVERR;
        end
    end

    always_ff @(posedge bus) begin
        if (rst) begin
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            pins_reg <= '0;
        end else begin
            awready <= w_accept;
            wready <= w_accept;
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (w_fire) begin
                bvalid <= 1'b1;
                // Pins move on the same edge that raises bvalid.
                if (w_range_ok) begin
                    for (int i = 0; i < 8; i++) begin
                        if (wstrb[i]) begin
                            pins_reg[waddr + i] <= wbits[i];
                        end
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Reads
    //////////////////////////////////////////////////

    assign raddr = ar.araddr & gpio_pkg::OFFSET_MASK;
    assign r_range_ok = (32'(raddr) + 8) <= gpio_pkg::OUT_REG_SIZE;
    assign ar_accept = arvalid && !arready && !rvalid;
    assign r_fire = arvalid && arready;

    // One pin per byte, in bit 0 of the lane.
    always_comb begin
        rdata_comb = '0;
        if (r_range_ok) begin
            for (int i = 0; i < 8; i++) begin
                rdata_comb[8*i] = pins_reg[raddr + i];
            end
        end
    end

    always_ff @(posedge bus) begin
        if (r_fire) begin
            r.rdata <= rdata_comb;
            r.rresp <= r_range_ok ? gpio_pkg::OKAY : gpio_pkg::SLVERR;
        end
    end

    always_ff @(posedge bus) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            arready <= ar_accept;
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if (r_fire) begin
                rvalid <= 1'b1;
            end
        end
    end

endmodule

// ==== design/gpio_in_bank.sv ====
`timescale 1ns/10ps

module gpio_in_bank (
    input  logic                         bus,
    input  logic                         rst,
    input  gpio_pkg::axil_ar_t           ar,
    input  logic                         arvalid,
    output logic                         arready,
    output gpio_pkg::axil_r_t            r,
    output logic                         rvalid,
    input  logic                         rready,
    input  logic [gpio_pkg::NUM_IN-1:0]  pins
);
    logic [gpio_pkg::NUM_IN-1:0] sync_q1;
    logic [gpio_pkg::NUM_IN-1:0] sync_q2;
    logic [gpio_pkg::IN_REG_SIZE-1:0] sampled;

    logic [gpio_pkg::ALEN-1:0] raddr;
    logic [gpio_pkg::DLEN-1:0] rdata_comb;
    logic ar_accept;
    logic r_fire;
    logic r_range_ok;

    //////////////////////////////////////////////////
    // Input synchronizer
    //////////////////////////////////////////////////

    // The pins are asynchronous to the bus clock. Two flops settle them before sampling.
    always_ff @(posedge bus) begin
        if (rst) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
            sampled <= '0;
        end else begin
            sync_q1 <= pins;
            sync_q2 <= sync_q1;
            sampled <= gpio_pkg::IN_REG_SIZE'(sync_q2);
        end
    end

    //////////////////////////////////////////////////
    // Reads
    //////////////////////////////////////////////////

    assign raddr = ar.araddr & gpio_pkg::OFFSET_MASK;
    assign r_range_ok = (32'(raddr) + 8) <= gpio_pkg::IN_REG_SIZE;
    assign ar_accept = arvalid && !arready && !rvalid;
    assign r_fire = arvalid && arready;

    always_comb begin
        rdata_comb = '0;
        if (r_range_ok) begin
            for (int i = 0; i < 8; i++) begin
                rdata_comb[8*i] = sampled[raddr + i];
            end
        end
    end

    always_ff @(posedge bus) begin
        if (r_fire) begin
            r.rdata <= rdata_comb;
            r.rresp <= r_range_ok ? gpio_pkg::OKAY : gpio_pkg::SLVERR;
        end
    end

    always_ff @(posedge bus) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            arready <= ar_accept;
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if (r_fire) begin
                rvalid <= 1'b1;
            end
        end
    end

endmodule

// ==== design/gpio_subsystem.sv ====
`timescale 1ns/10ps

module gpio_subsystem (
    input  logic                          bus,
    input  logic                          rst,
    input  gpio_pkg::axil_aw_t            aw,
    input  logic                          awvalid,
    output logic                          awready,
    input  gpio_pkg::axil_w_t             w,
    input  logic                          wvalid,
    output logic                          wready,
    output gpio_pkg::axil_b_t             b,
    output logic                          bvalid,
    input  logic                          bready,
    input  gpio_pkg::axil_ar_t            ar,
    input  logic                          arvalid,
    output logic                          arready,
    output gpio_pkg::axil_r_t             r,
    output logic                          rvalid,
    input  logic                          rready,
    input  logic [gpio_pkg::NUM_IN-1:0]   pins_in,
    output logic [gpio_pkg::NUM_OUT-1:0]  pins_out
);
    gpio_pkg::axil_aw_t out_aw;
    gpio_pkg::axil_w_t  out_w;
    gpio_pkg::axil_b_t  out_b;
    gpio_pkg::axil_ar_t out_ar;
    gpio_pkg::axil_r_t  out_r;
    logic out_awvalid;
    logic out_awready;
    logic out_wvalid;
    logic out_wready;
    logic out_bvalid;
    logic out_bready;
    logic out_arvalid;
    logic out_arready;
    logic out_rvalid;
    logic out_rready;

    gpio_pkg::axil_ar_t in_ar;
    gpio_pkg::axil_r_t  in_r;
    logic in_arvalid;
    logic in_arready;
    logic in_rvalid;
    logic in_rready;

    axil_decoder i_decoder (
        .bus         (bus),
        .rst         (rst),
        .aw          (aw),
        .awvalid     (awvalid),
        .awready     (awready),
        .w           (w),
        .wvalid      (wvalid),
        .wready      (wready),
        .b           (b),
        .bvalid      (bvalid),
        .bready      (bready),
        .ar          (ar),
        .arvalid     (arvalid),
        .arready     (arready),
        .r           (r),
        .rvalid      (rvalid),
        .rready      (rready),
        .out_aw      (out_aw),
        .out_awvalid (out_awvalid),
        .out_awready (out_awready),
        .out_w       (out_w),
        .out_wvalid  (out_wvalid),
        .out_wready  (out_wready),
        .out_b       (out_b),
        .out_bvalid  (out_bvalid),
        .out_bready  (out_bready),
        .out_ar      (out_ar),
        .out_arvalid (out_arvalid),
        .out_arready (out_arready),
        .out_r       (out_r),
        .out_rvalid  (out_rvalid),
        .out_rready  (out_rready),
        .in_ar       (in_ar),
        .in_arvalid  (in_arvalid),
        .in_arready  (in_arready),
        .in_r        (in_r),
        .in_rvalid   (in_rvalid),
        .in_rready   (in_rready)
    );

    gpio_out_bank i_out (
        .bus     (bus),
        .rst     (rst),
        .aw      (out_aw),
        .awvalid (out_awvalid),
        .awready (out_awready),
        .w       (out_w),
        .wvalid  (out_wvalid),
        .wready  (out_wready),
        .b       (out_b),
        .bvalid  (out_bvalid),
        .bready  (out_bready),
        .ar      (out_ar),
        .arvalid (out_arvalid),
        .arready (out_arready),
        .r       (out_r),
        .rvalid  (out_rvalid),
        .rready  (out_rready),
        .pins    (pins_out)
    );

    gpio_in_bank i_in (
        .bus     (bus),
        .rst     (rst),
        .ar      (in_ar),
        .arvalid (in_arvalid),
        .arready (in_arready),
        .r       (in_r),
        .rvalid  (in_rvalid),
        .rready  (in_rready),
        .pins    (pins_in)
    );

endmodule

// ==== test/gpio_subsystem_chk.sv ====
`timescale 1ns/10ps

module gpio_subsystem_chk (
    input  logic                          bus,
    input  logic                          rst,
    input  gpio_pkg::axil_b_t             b,
    input  logic                          bvalid,
    input  logic                          bready,
    input  gpio_pkg::axil_r_t             r,
    input  logic                          rvalid,
    input  logic                          rready,
    input  logic [gpio_pkg::NUM_OUT-1:0]  pins_out
);
    int unsigned fail_count = 0;

    //////////////////////////////////////////////////
    // Response channels
    //////////////////////////////////////////////////

    b_held: assert property (@(posedge bus) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(b))
        else begin
            $error("Write response dropped or changed before bready.");
            fail_count++;
        end

    r_held: assert property (@(posedge bus) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(r))
        else begin
            $error("Read response dropped or changed before rready.");
            fail_count++;
        end

    // Quiet through reset and for the first cycle after release.
    reset_quiet: assert property (@(posedge bus) rst |=> !bvalid && !rvalid)
        else begin
            $error("Response valid high during reset.");
            fail_count++;
        end

    release_quiet: assert property (@(posedge bus) $fell(rst) |=> !bvalid && !rvalid)
        else begin
            $error("Response valid high in the cycle after reset.");
            fail_count++;
        end

    //////////////////////////////////////////////////
    // Output pins
    //////////////////////////////////////////////////

    pins_on_bvalid: assert property (@(posedge bus) disable iff (rst)
        !$stable(pins_out) |-> $rose(bvalid))
        else begin
            $error("Output pins changed without a new write response.");
            fail_count++;
        end

endmodule

bind gpio_subsystem gpio_subsystem_chk i_chk (
    .bus      (bus),
    .rst      (rst),
    .b        (b),
    .bvalid   (bvalid),
    .bready   (bready),
    .r        (r),
    .rvalid   (rvalid),
    .rready   (rready),
    .pins_out (pins_out)
);

// ==== test/tb_gpio_subsystem.sv ====
`timescale 1ns/10ps

module tb_gpio_subsystem;

    // About 100 transactions, none of which needs more than 20 cycles with its stalls.
    localparam int NUM_TRANSACTIONS = 100;
    localparam int MAX_CYCLES_PER_TRANSACTION = 20;
    localparam int TIMEOUT_CYCLES = NUM_TRANSACTIONS * MAX_CYCLES_PER_TRANSACTION;

    logic bus = 1'b0;
    logic rst;
    gpio_pkg::axil_aw_t aw;
    gpio_pkg::axil_w_t w;
    gpio_pkg::axil_b_t b;
    gpio_pkg::axil_ar_t ar;
    gpio_pkg::axil_r_t r;
    logic awvalid;
    logic awready;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;
    logic arvalid;
    logic arready;
    logic rvalid;
    logic rready;
    logic [gpio_pkg::NUM_IN-1:0] pins_in;
    logic [gpio_pkg::NUM_OUT-1:0] pins_out;

    integer seed;
    int unsigned cycles = 0;
    int unsigned errors;
    int unsigned test_errors;
    int unsigned tests_run;
    int unsigned tests_failed;
    logic [gpio_pkg::NUM_OUT-1:0] exp_pins;
    logic [gpio_pkg::NUM_IN-1:0] exp_in;

    gpio_subsystem i_dut (
        .bus      (bus),
        .rst      (rst),
        .aw       (aw),
        .awvalid  (awvalid),
        .awready  (awready),
        .w        (w),
        .wvalid   (wvalid),
        .wready   (wready),
        .b        (b),
        .bvalid   (bvalid),
        .bready   (bready),
        .ar       (ar),
        .arvalid  (arvalid),
        .arready  (arready),
        .r        (r),
        .rvalid   (rvalid),
        .rready   (rready),
        .pins_in  (pins_in),
        .pins_out (pins_out)
    );

    always #10 bus = ~bus;

    always @(posedge bus) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a handshake never completed.", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Bus master
    //////////////////////////////////////////////////

    // Moves to 1 ns after the next rising edge, where inputs are driven and outputs sampled.
    task automatic step();
        @(posedge bus);
        #1;
    endtask

    task automatic axi_write(input logic [15:0] addr, input logic [63:0] data,
                             input logic [7:0] strb, input int bdelay,
                             output gpio_pkg::resp_e resp);
        aw.awaddr = addr;
        w.wdata = data;
        w.wstrb = strb;
        awvalid = 1'b1;
        wvalid = 1'b1;
        while (!(awready && wready)) step();
        step();
        awvalid = 1'b0;
        wvalid = 1'b0;
        while (!bvalid) step();
        repeat (bdelay) step();
        bready = 1'b1;
        resp = b.bresp;
        step();
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [15:0] addr, input int rdelay,
                            output logic [63:0] data, output gpio_pkg::resp_e resp);
        ar.araddr = addr;
        arvalid = 1'b1;
        while (!arready) step();
        step();
        arvalid = 1'b0;
        while (!rvalid) step();
        repeat (rdelay) step();
        rready = 1'b1;
        data = r.rdata;
        resp = r.rresp;
        step();
        rready = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Pin off+i lands in bit 0 of byte i. A window past the bank reads as zero.
    function automatic logic [63:0] spread_pins(input logic [15:0] src, input int off,
                                                input int size);
        logic [63:0] word;
        word = '0;
        if (off + 8 <= size) begin
            for (int i = 0; i < 8; i++) begin
                word[8*i] = src[off+i];
            end
        end
        return word;
    endfunction

    function automatic gpio_pkg::resp_e expected_resp(input logic [15:0] addr,
                                                      input logic is_write);
        int off;
        off = int'(addr[11:0]);
        if (addr[15:12] == 4'd0) begin
            if (off + 8 <= 16) return gpio_pkg::OKAY;
            return gpio_pkg::SLVERR;
        end
        if (addr[15:12] == 4'd1 && !is_write) begin
            if (off + 8 <= 12) return gpio_pkg::OKAY;
            return gpio_pkg::SLVERR;
        end
        return gpio_pkg::DECERR;
    endfunction

    function automatic logic [63:0] expected_rdata(input logic [15:0] addr);
        int off;
        off = int'(addr[11:0]);
        if (addr[15:12] == 4'd0) return spread_pins(exp_pins, off, 16);
        if (addr[15:12] == 4'd1) return spread_pins({4'b0000, exp_in}, off, 12);
        return '0;
    endfunction

    task automatic model_write(input logic [15:0] addr, input logic [63:0] data,
                               input logic [7:0] strb);
        int off;
        off = int'(addr[11:0]);
        if (expected_resp(addr, 1'b1) == gpio_pkg::OKAY) begin
            for (int i = 0; i < 8; i++) begin
                if (strb[i]) exp_pins[off+i] = data[8*i];
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Checks and reporting
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp) else begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic write_and_check(input string name, input logic [15:0] addr,
                                   input logic [63:0] data, input logic [7:0] strb,
                                   input int bdelay);
        gpio_pkg::resp_e resp;
        axi_write(addr, data, strb, bdelay, resp);
        check_value({name, " bresp"}, 64'(expected_resp(addr, 1'b1)), 64'(resp));
        model_write(addr, data, strb);
        check_value({name, " pins_out"}, 64'(exp_pins), 64'(pins_out));
    endtask

    task automatic read_and_check(input string name, input logic [15:0] addr,
                                  input int rdelay);
        logic [63:0] data;
        gpio_pkg::resp_e resp;
        axi_read(addr, rdelay, data, resp);
        check_value({name, " rresp"}, 64'(expected_resp(addr, 1'b0)), 64'(resp));
        check_value({name, " rdata"}, expected_rdata(addr), data);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic sample_new_inputs();
        pins_in = 12'($random(seed));
        exp_in = pins_in;
        repeat (5) step();
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    initial begin
        int off;
        int delay;
        logic [7:0] strb;

        seed = 17;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        exp_pins = '0;
        exp_in = '0;
        rst = 1'b1;
        aw = '0;
        awvalid = 1'b0;
        w = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        ar = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        pins_in = '0;
        repeat (5) @(posedge bus);
        #1;
        rst = 1'b0;
        step();

        check_value("reset pins_out", 64'(exp_pins), 64'(pins_out));
        check_value("reset handshake", 64'(0),
                    64'({awready, wready, bvalid, arready, rvalid}));
        read_and_check("reset", 16'h0000, 0);
        end_test("reset");

        for (int k = 0; k <= 8; k++) begin
            write_and_check("full_strobe", 16'(k), {$random(seed), $random(seed)}, 8'hFF, 0);
        end
        for (int k = 0; k <= 8; k++) begin
            read_and_check("full_strobe", 16'(k), 0);
        end
        end_test("full_strobe");

        repeat (12) begin
            off = int'($unsigned($random(seed)) % 9);
            strb = 8'($random(seed));
            write_and_check("partial_strobe", 16'(off), {$random(seed), $random(seed)}, strb, 0);
            read_and_check("partial_strobe", 16'(off), 0);
        end
        read_and_check("partial_strobe", 16'h0000, 0);
        read_and_check("partial_strobe", 16'h0008, 0);
        end_test("partial_strobe");

        write_and_check("out_of_range", 16'h0009, {$random(seed), $random(seed)}, 8'hFF, 0);
        write_and_check("out_of_range", 16'h000C, {$random(seed), $random(seed)}, 8'hFF, 0);
        write_and_check("out_of_range", 16'h0FF8, {$random(seed), $random(seed)}, 8'hFF, 0);
        read_and_check("out_of_range", 16'h0009, 0);
        read_and_check("out_of_range", 16'h0FFF, 0);
        read_and_check("out_of_range", 16'h1005, 0);
        read_and_check("out_of_range", 16'h1008, 0);
        end_test("out_of_range");

        repeat (4) begin
            sample_new_inputs();
            read_and_check("input_bank", 16'h1000, 0);
            read_and_check("input_bank", 16'h1004, 0);
        end
        write_and_check("unmapped", 16'h2000, {$random(seed), $random(seed)}, 8'hFF, 0);
        read_and_check("unmapped", 16'h2000, 0);
        write_and_check("unmapped", 16'h1000, {$random(seed), $random(seed)}, 8'hFF, 0);
        read_and_check("unmapped", 16'hF008, 0);
        end_test("input_and_unmapped");

        repeat (6) begin
            off = int'($unsigned($random(seed)) % 9);
            delay = 1 + int'($unsigned($random(seed)) % 6);
            write_and_check("backpressure", 16'(off), {$random(seed), $random(seed)},
                            8'hFF, delay);
            delay = 1 + int'($unsigned($random(seed)) % 6);
            read_and_check("backpressure", 16'(off), delay);
        end
        sample_new_inputs();
        // Each pair touches disjoint pins, so the order of completion does not matter.
        fork
            write_and_check("overlap", 16'h0000, {$random(seed), $random(seed)}, 8'hFF, 2);
            read_and_check("overlap", 16'h1000, 1);
        join
        fork
            write_and_check("overlap", 16'h0000, {$random(seed), $random(seed)}, 8'h5A, 0);
            read_and_check("overlap", 16'h0008, 3);
        join
        read_and_check("overlap", 16'h0000, 0);
        end_test("backpressure_and_overlap");

        repeat (3) step();
        if (i_dut.i_chk.fail_count != 0) begin
            $display("The protocol checker saw %0d assertion failures.",
                     i_dut.i_chk.fail_count);
        end
        $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, errors, i_dut.i_chk.fail_count);
        if (errors == 0 && tests_failed == 0 && i_dut.i_chk.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
design/gpio_pkg.sv
design/axil_decoder.sv
design/gpio_out_bank.sv
design/gpio_in_bank.sv
design/gpio_subsystem.sv
test/gpio_subsystem_chk.sv
test/tb_gpio_subsystem.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the GPIO subsystem testbench with Verilator, runs it and checks for the pass line.
# The error limit is raised so that assertion failures reach the testbench summary.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_gpio_subsystem -f all.f \
    && ./obj_dir/Vtb_gpio_subsystem +verilator+error+limit+1000 \
        | tee /dev/stderr | grep -x "Test OK" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
